/* Bender.yml */
package:
  name: rv32i_execute

sources:
  - src/rv32i_types.sv
  - src/rv32i_ctrl_types.sv
  - src/control_rom.sv
  - src/operand_select.sv
  - src/alu.sv
  - src/cmp.sv
  - src/instruction_execute.sv
  - src/execute_top.sv
  - target: test
    files:
      - tests/execute_assert.sv
      - tests/execute_tb.sv

/* src/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu
  import rv32i_types::*;
  import rv32i_ctrl_types::*;
(
  input  alu_ops    aluop,
  input  rv32i_word a,
  input  rv32i_word b,
  output rv32i_word f
);

  logic [4:0] shamt;

  assign shamt = b[4:0]; // upper bits ignored

  always_comb begin
    unique case (aluop)
      alu_add:  f = a + b;
      alu_sub:  f = a - b;
      alu_sll:  f = a << shamt;
      alu_slt:  f = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      alu_sltu: f = {{(XLEN-1){1'b0}}, a < b};
      alu_xor:  f = a ^ b;
      alu_srl:  f = a >> shamt;
      alu_sra:  f = rv32i_word'($signed(a) >>> shamt); // sign fill
      alu_or:   f = a | b;
      alu_and:  f = a & b;
      default:  f = a + b; // spare encodings
    endcase
  end

endmodule

`default_nettype wire

/* src/cmp.sv */
`timescale 1ns/1ps
`default_nettype none

module cmp
  import rv32i_types::*;
  import rv32i_ctrl_types::*;
(
  input  cmp_ops    cmpop,
  input  rv32i_word rs1_out,
  input  rv32i_word cmp_in,
  output logic      br_en
);

  always_comb begin
    unique case (cmpop)
      beq:     br_en = (rs1_out == cmp_in);
      bne:     br_en = (rs1_out != cmp_in);
      blt:     br_en = ($signed(rs1_out) < $signed(cmp_in)); // also slt
      bge:     br_en = ($signed(rs1_out) >= $signed(cmp_in));
      bltu:    br_en = (rs1_out < cmp_in); // also sltu
      bgeu:    br_en = (rs1_out >= cmp_in);
      default: br_en = 1'b0; // reserved funct3
    endcase
  end

endmodule

`default_nettype wire

/* src/control_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module control_rom
  import rv32i_types::*;
  import rv32i_ctrl_types::*;
(
  input  rv32i_word         instruction,
  output rv32i_control_word ctrl
);

  rv32i_opcode   opcode;
  arith_funct3_t funct3;
  logic          bit30;
  logic          is_reg;

  assign opcode = rv32i_opcode'(instruction[6:0]);
  assign funct3 = arith_funct3_t'(instruction[14:12]);
  assign bit30  = instruction[30]; // funct7 bit 5
  assign is_reg = (opcode == op_reg);

  always_comb begin
    ctrl                = '0; // no write, no memory access
    ctrl.opcode         = opcode;
    ctrl.aluop          = alu_add;
    ctrl.cmpop          = beq;
    ctrl.alumux1_sel    = alu1_rs1;
    ctrl.alumux2_sel    = alu2_i_imm;
    ctrl.cmpmux_sel     = cmpmux_rs2;
    ctrl.regfilemux_sel = rf_alu_out;

    unique case (opcode)
      op_lui: begin
        ctrl.regfilemux_sel = rf_u_imm;
        ctrl.load_regfile   = 1'b1;
      end
      op_auipc: begin
        ctrl.alumux1_sel  = alu1_pc;
        ctrl.alumux2_sel  = alu2_u_imm;
        ctrl.load_regfile = 1'b1;
      end
      op_jal: begin
        ctrl.alumux1_sel    = alu1_pc; // jump target
        ctrl.alumux2_sel    = alu2_j_imm;
        ctrl.regfilemux_sel = rf_pc_plus4;
        ctrl.load_regfile   = 1'b1;
      end
      op_jalr: begin
        ctrl.regfilemux_sel = rf_pc_plus4; // target is rs1 + i_imm
        ctrl.load_regfile   = 1'b1;
      end
      op_br: begin
        ctrl.cmpop       = cmp_ops'(instruction[14:12]);
        ctrl.alumux1_sel = alu1_pc;
        ctrl.alumux2_sel = alu2_b_imm;
      end
      op_load: begin
        ctrl.regfilemux_sel = rf_load;
        ctrl.load_regfile   = 1'b1;
        ctrl.mem_read       = 1'b1;
      end
      op_store: begin
        ctrl.alumux2_sel = alu2_s_imm;
        ctrl.mem_write   = 1'b1;
      end
      op_imm, op_reg: begin
        ctrl.load_regfile = 1'b1;
        ctrl.alumux2_sel  = is_reg ? alu2_rs2 : alu2_i_imm;
        ctrl.cmpmux_sel   = is_reg ? cmpmux_rs2 : cmpmux_i_imm;
        unique case (funct3)
          add:  ctrl.aluop = (is_reg && bit30) ? alu_sub : alu_add; // no subi
          sll:  ctrl.aluop = alu_sll;
          slt: begin
            ctrl.aluop          = alu_slt;
            ctrl.cmpop          = blt; // result comes from the comparator
            ctrl.regfilemux_sel = rf_br_en;
          end
          sltu: begin
            ctrl.aluop          = alu_sltu;
            ctrl.cmpop          = bltu;
            ctrl.regfilemux_sel = rf_br_en;
          end
          axor: ctrl.aluop = alu_xor;
          sr:   ctrl.aluop = bit30 ? alu_sra : alu_srl;
          aor:  ctrl.aluop = alu_or;
          aand: ctrl.aluop = alu_and;
        endcase
      end
      default: begin
        ctrl.load_regfile = 1'b0; // unknown opcode is a bubble
      end
    endcase
  end

endmodule

`default_nettype wire

/* src/execute_top.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_top
  import rv32i_types::*;
  import rv32i_ctrl_types::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    in_valid,
  output logic    in_ready,
  input  id_ex_t  id_in,
  output logic    out_valid,
  input  logic    out_ready,
  output ex_mem_t ex_out
);

  rv32i_control_word ctrl;
  rv32i_word         alu_in_1;
  rv32i_word         alu_in_2;
  rv32i_word         cmp_in;

  // decode straight off the incoming record
  control_rom u_control_rom (
    .instruction (id_in.instruction),
    .ctrl        (ctrl)
  );

  operand_select u_operand_select (
    .rec      (id_in),
    .ctrl     (ctrl),
    .alu_in_1 (alu_in_1),
    .alu_in_2 (alu_in_2),
    .cmp_in   (cmp_in)
  );

  instruction_execute u_execute (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .rec          (id_in),
    .ctrl_word_in (ctrl),
    .alu_in_1     (alu_in_1),
    .alu_in_2     (alu_in_2),
    .cmp_in       (cmp_in),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .ex_out       (ex_out)
  );

endmodule

`default_nettype wire

/* src/instruction_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module instruction_execute
  import rv32i_types::*;
  import rv32i_ctrl_types::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid,
  output logic              in_ready,
  input  id_ex_t            rec,
  input  rv32i_control_word ctrl_word_in,
  input  rv32i_word         alu_in_1,
  input  rv32i_word         alu_in_2,
  input  rv32i_word         cmp_in,
  output logic              out_valid,
  input  logic              out_ready,
  output ex_mem_t           ex_out
);

  rv32i_word  alu_f;
  logic       br_en;
  logic [1:0] offset;
  logic [3:0] mem_byte_enable;
  ex_mem_t    ex_next;
  logic       accept;

  //////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////

  alu u_alu (
    .aluop (ctrl_word_in.aluop),
    .a     (alu_in_1),
    .b     (alu_in_2),
    .f     (alu_f)
  );

  cmp u_cmp (
    .cmpop   (ctrl_word_in.cmpop),
    .rs1_out (rec.rs1_data),
    .cmp_in  (cmp_in),
    .br_en   (br_en)
  );

  // byte lanes from access width and address offset
  assign offset = alu_f[1:0];

  always_comb begin
    unique case (load_funct3_t'(rec.instruction[14:12]))
      lb, lbu: mem_byte_enable = 4'b0001 << offset; // one lane
      lh, lhu: mem_byte_enable = 4'b0011 << offset; // lane 4 falls off
      lw:      mem_byte_enable = 4'b1111 << offset;
      default: mem_byte_enable = 4'b1111;
    endcase
  end

  always_comb begin
    ex_next.ctrl            = ctrl_word_in;
    ex_next.instruction     = rec.instruction;
    ex_next.pc              = rec.pc;
    ex_next.alu_out         = alu_f;
    ex_next.rs2_out         = rec.rs2_data; // masked later in mem stage
    ex_next.br_en           = br_en;
    ex_next.mem_byte_enable = mem_byte_enable;
  end

  //////////////////////////////////////////////////
  // stage register with valid/ready
  //////////////////////////////////////////////////

  assign in_ready = !out_valid || out_ready; // empty or draining
  assign accept   = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      ex_out    <= '0;
    end else begin
      if (in_ready) begin
        out_valid <= in_valid; // bubble when nothing arrives
      end
      if (accept) begin
        ex_out <= ex_next;
      end
    end
  end

endmodule

`default_nettype wire

/* src/operand_select.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_select
  import rv32i_types::*;
  import rv32i_ctrl_types::*;
(
  input  id_ex_t            rec,
  input  rv32i_control_word ctrl,
  output rv32i_word         alu_in_1,
  output rv32i_word         alu_in_2,
  output rv32i_word         cmp_in
);

  rv32i_word instr;
  rv32i_word i_imm;
  rv32i_word s_imm;
  rv32i_word b_imm;
  rv32i_word u_imm;
  rv32i_word j_imm;

  assign instr = rec.instruction;

  //////////////////////////////////////////////////
  // immediates, all sign extended from bit 31
  //////////////////////////////////////////////////

  assign i_imm = {{21{instr[31]}}, instr[30:20]};
  assign s_imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
  assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign u_imm = {instr[31:12], 12'h000};
  assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  //////////////////////////////////////////////////
  // operand muxes
  //////////////////////////////////////////////////

  assign alu_in_1 = (ctrl.alumux1_sel == alu1_pc) ? rec.pc : rec.rs1_data;

  always_comb begin
    unique case (ctrl.alumux2_sel)
      alu2_i_imm: alu_in_2 = i_imm;
      alu2_u_imm: alu_in_2 = u_imm;
      alu2_b_imm: alu_in_2 = b_imm;
      alu2_s_imm: alu_in_2 = s_imm;
      alu2_j_imm: alu_in_2 = j_imm;
      default:    alu_in_2 = rec.rs2_data; // alu2_rs2
    endcase
  end

  // slti and sltiu compare against the immediate
  assign cmp_in = (ctrl.cmpmux_sel == cmpmux_i_imm) ? i_imm : rec.rs2_data;

endmodule

`default_nettype wire

/* src/rv32i_ctrl_types.sv */
`default_nettype none

package rv32i_ctrl_types;
  import rv32i_types::*;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_ops;

  typedef branch_funct3_t cmp_ops; // compare op is the branch funct3

  typedef enum logic {alu1_rs1, alu1_pc} alumux1_sel_t;

  typedef enum logic [2:0] {
    alu2_i_imm,
    alu2_u_imm,
    alu2_b_imm,
    alu2_s_imm,
    alu2_j_imm,
    alu2_rs2
  } alumux2_sel_t;

  typedef enum logic {cmpmux_rs2, cmpmux_i_imm} cmpmux_sel_t;

  // consumed by writeback, carried along here
  typedef enum logic [2:0] {
    rf_alu_out,
    rf_br_en,
    rf_u_imm,
    rf_pc_plus4,
    rf_load
  } regfilemux_sel_t;

  typedef struct packed {
    rv32i_opcode     opcode;
    alu_ops          aluop;
    cmp_ops          cmpop;
    alumux1_sel_t    alumux1_sel;
    alumux2_sel_t    alumux2_sel;
    cmpmux_sel_t     cmpmux_sel;
    regfilemux_sel_t regfilemux_sel;
    logic            load_regfile;
    logic            mem_read;
    logic            mem_write;
  } rv32i_control_word;

  typedef struct packed {
    rv32i_word pc;
    rv32i_word instruction;
    rv32i_word rs1_data; // already read from the register file
    rv32i_word rs2_data;
  } id_ex_t;

  typedef struct packed {
    rv32i_control_word ctrl;
    rv32i_word         instruction;
    rv32i_word         pc;
    rv32i_word         alu_out;
    rv32i_word         rs2_out;   // store data, unmasked
    logic              br_en;
    logic [3:0]        mem_byte_enable;
  } ex_mem_t;

endpackage

`default_nettype wire

/* src/rv32i_types.sv */
`default_nettype none

package rv32i_types;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] rv32i_word;

  //////////////////////////////////////////////////
  // base opcodes, bits 6:0
  //////////////////////////////////////////////////

  typedef enum logic [6:0] {
    op_lui   = 7'b0110111, // load upper immediate
    op_auipc = 7'b0010111, // add upper immediate to pc
    op_jal   = 7'b1101111,
    op_jalr  = 7'b1100111,
    op_br    = 7'b1100011, // conditional branches
    op_load  = 7'b0000011,
    op_store = 7'b0100011,
    op_imm   = 7'b0010011, // register-immediate alu
    op_reg   = 7'b0110011  // register-register alu
  } rv32i_opcode;

  //////////////////////////////////////////////////
  // funct3 encodings, bits 14:12
  //////////////////////////////////////////////////

  typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } branch_funct3_t;

  // stores use the same width codes
  typedef enum logic [2:0] {
    lb  = 3'b000,
    lh  = 3'b001,
    lw  = 3'b010,
    lbu = 3'b100,
    lhu = 3'b101
  } load_funct3_t;

  typedef enum logic [2:0] {
    add  = 3'b000, // sub when bit 30 set on op_reg
    sll  = 3'b001,
    slt  = 3'b010,
    sltu = 3'b011,
    axor = 3'b100,
    sr   = 3'b101, // srl or sra by bit 30
    aor  = 3'b110,
    aand = 3'b111
  } arith_funct3_t;

endpackage

`default_nettype wire

/* tests/execute_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_assert
  import rv32i_ctrl_types::*;
(
  input logic    clk,
  input logic    rst,
  input logic    in_ready,
  input logic    out_valid,
  input logic    out_ready,
  input ex_mem_t ex_out
);

  // stage comes out of reset empty
  assert property (@(posedge clk) rst |=> !out_valid)
    else $error("out_valid high in the cycle after reset");

  assert property (@(posedge clk) disable iff (rst)
    (out_valid && !out_ready) |=> (out_valid && $stable(ex_out)))
    else $error("stalled record changed or was dropped");

  assert property (@(posedge clk) disable iff (rst)
    in_ready == (!out_valid || out_ready))
    else $error("in_ready does not follow out_valid and out_ready");

endmodule

bind instruction_execute execute_assert u_execute_assert (
  .clk       (clk),
  .rst       (rst),
  .in_ready  (in_ready),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .ex_out    (ex_out)
);

`default_nettype wire

/* tests/execute_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_tb
  import rv32i_types::*;
  import rv32i_ctrl_types::*;
();

  localparam int clk_period  = 4;
  localparam int n_arith     = 40;
  localparam int n_cmp       = 64;
  localparam int n_be        = 32;
  localparam int n_bp        = 48;
  localparam int n_unknown   = 4;
  localparam int total_items = n_arith + n_cmp + n_be + n_bp + n_unknown;
  localparam int watchdog_ns = (total_items * 20 + 200) * clk_period;

  logic    clk;
  logic    rst;
  logic    in_valid;
  logic    in_ready;
  id_ex_t  id_in;
  logic    out_valid;
  logic    out_ready;
  ex_mem_t ex_out;

  integer  seed;
  int      errors;
  int      checked;
  int      issued;
  int      tests_run;
  ex_mem_t exp_q[$];
  ex_mem_t exp_rec;
  logic    bp_on;
  logic    bp_pattern [0:255];
  int      bp_idx;

  execute_top dut (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .id_in     (id_in),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .ex_out    (ex_out)
  );

  always #(clk_period / 2) clk = ~clk;

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////

  task automatic check_word(input string name, input rv32i_word got, input rv32i_word exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_ctrl(input string name, input rv32i_control_word got,
                            input rv32i_control_word exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_be(input string name, input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic compare_record(input ex_mem_t got, input ex_mem_t exp);
    check_ctrl("ex_out.ctrl", got.ctrl, exp.ctrl);
    check_word("ex_out.instruction", got.instruction, exp.instruction);
    check_word("ex_out.pc", got.pc, exp.pc);
    check_word("ex_out.alu_out", got.alu_out, exp.alu_out);
    check_word("ex_out.rs2_out", got.rs2_out, exp.rs2_out);
    check_bit("ex_out.br_en", got.br_en, exp.br_en);
    check_be("ex_out.mem_byte_enable", got.mem_byte_enable, exp.mem_byte_enable);
  endtask

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  function automatic rv32i_word imm_i(rv32i_word ins);
    return {{20{ins[31]}}, ins[31:20]};
  endfunction

  function automatic rv32i_word imm_s(rv32i_word ins);
    return {{20{ins[31]}}, ins[31:25], ins[11:7]};
  endfunction

  function automatic rv32i_word imm_b(rv32i_word ins);
    return {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
  endfunction

  function automatic rv32i_word imm_u(rv32i_word ins);
    return {ins[31:12], 12'b0};
  endfunction

  function automatic rv32i_word imm_j(rv32i_word ins);
    return {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
  endfunction

  function automatic rv32i_control_word decode_ref(rv32i_word ins);
    rv32i_control_word c;
    logic [2:0]        f3;
    c        = '0; // all selects and ops at their first encoding
    c.opcode = rv32i_opcode'(ins[6:0]);
    f3       = ins[14:12];
    case (ins[6:0])
      op_lui: begin
        c.regfilemux_sel = rf_u_imm;
        c.load_regfile   = 1'b1;
      end
      op_auipc: begin
        c.alumux1_sel  = alu1_pc;
        c.alumux2_sel  = alu2_u_imm;
        c.load_regfile = 1'b1;
      end
      op_jal: begin
        c.alumux1_sel    = alu1_pc;
        c.alumux2_sel    = alu2_j_imm;
        c.regfilemux_sel = rf_pc_plus4;
        c.load_regfile   = 1'b1;
      end
      op_jalr: begin
        c.regfilemux_sel = rf_pc_plus4;
        c.load_regfile   = 1'b1;
      end
      op_br: begin
        c.cmpop       = cmp_ops'(f3);
        c.alumux1_sel = alu1_pc;
        c.alumux2_sel = alu2_b_imm;
      end
      op_load: begin
        c.regfilemux_sel = rf_load;
        c.load_regfile   = 1'b1;
        c.mem_read       = 1'b1;
      end
      op_store: begin
        c.alumux2_sel = alu2_s_imm;
        c.mem_write   = 1'b1;
      end
      op_imm, op_reg: begin
        c.load_regfile = 1'b1;
        if (ins[6:0] == op_reg) begin
          c.alumux2_sel = alu2_rs2;
        end else begin
          c.cmpmux_sel = cmpmux_i_imm;
        end
        case (f3)
          3'b000: c.aluop = (ins[6:0] == op_reg && ins[30]) ? alu_sub : alu_add;
          3'b001: c.aluop = alu_sll;
          3'b010: begin
            c.aluop          = alu_slt;
            c.cmpop          = blt;
            c.regfilemux_sel = rf_br_en;
          end
          3'b011: begin
            c.aluop          = alu_sltu;
            c.cmpop          = bltu;
            c.regfilemux_sel = rf_br_en;
          end
          3'b100: c.aluop = alu_xor;
          3'b101: c.aluop = ins[30] ? alu_sra : alu_srl;
          3'b110: c.aluop = alu_or;
          default: c.aluop = alu_and;
        endcase
      end
      default: ; // unknown opcode writes nothing
    endcase
    return c;
  endfunction

  function automatic rv32i_word alu_ref(alu_ops op, rv32i_word a, rv32i_word b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      alu_add:  return a + b;
      alu_sub:  return a - b;
      alu_sll:  return a << sh;
      alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      alu_sltu: return (a < b) ? 32'd1 : 32'd0;
      alu_xor:  return a ^ b;
      alu_srl:  return a >> sh;
      alu_sra:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0); // sign fill
      alu_or:   return a | b;
      default:  return a & b;
    endcase
  endfunction

  function automatic logic cmp_ref(cmp_ops op, rv32i_word x, rv32i_word y);
    logic lt_s;
    lt_s = (x ^ 32'h8000_0000) < (y ^ 32'h8000_0000); // signed via biased order
    case (op)
      beq:     return x == y;
      bne:     return x != y;
      blt:     return lt_s;
      bge:     return !lt_s;
      bltu:    return x < y;
      bgeu:    return !(x < y);
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [3:0] lanes_ref(logic [2:0] f3, logic [1:0] addr);
    logic [3:0] m;
    int         off;
    off = addr;
    for (int i = 0; i < 4; i++) begin
      case (f3)
        3'b000, 3'b100: m[i] = (i == off);
        3'b001, 3'b101: m[i] = (i == off) || (i == off + 1); // clipped at lane 3
        3'b010:         m[i] = (i >= off);
        default:        m[i] = 1'b1;
      endcase
    end
    return m;
  endfunction

  function automatic ex_mem_t predict(id_ex_t r);
    ex_mem_t           e;
    rv32i_control_word c;
    rv32i_word         a;
    rv32i_word         b;
    rv32i_word         cin;
    c = decode_ref(r.instruction);
    a = (c.alumux1_sel == alu1_pc) ? r.pc : r.rs1_data;
    case (c.alumux2_sel)
      alu2_i_imm: b = imm_i(r.instruction);
      alu2_u_imm: b = imm_u(r.instruction);
      alu2_b_imm: b = imm_b(r.instruction);
      alu2_s_imm: b = imm_s(r.instruction);
      alu2_j_imm: b = imm_j(r.instruction);
      default:    b = r.rs2_data;
    endcase
    cin                 = (c.cmpmux_sel == cmpmux_i_imm) ? imm_i(r.instruction) : r.rs2_data;
    e.ctrl              = c;
    e.instruction       = r.instruction;
    e.pc                = r.pc;
    e.alu_out           = alu_ref(c.aluop, a, b);
    e.rs2_out           = r.rs2_data;
    e.br_en             = cmp_ref(c.cmpop, r.rs1_data, cin);
    e.mem_byte_enable   = lanes_ref(r.instruction[14:12], e.alu_out[1:0]);
    return e;
  endfunction

  //////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////

  function automatic rv32i_word make_instr(logic [6:0] op, logic [2:0] f3, logic b30);
    rv32i_word ins;
    ins        = $random(seed); // register and immediate fields random
    ins[6:0]   = op;
    ins[14:12] = f3;
    ins[30]    = b30;
    if (op == op_reg) begin
      ins[31]    = 1'b0;
      ins[29:25] = 5'b0;
    end
    return ins;
  endfunction

  function automatic id_ex_t make_rec(rv32i_word ins);
    id_ex_t r;
    r.pc          = $random(seed);
    r.pc[1:0]     = 2'b00;
    r.instruction = ins;
    r.rs1_data    = $random(seed);
    r.rs2_data    = $random(seed);
    return r;
  endfunction

  // called on a rising edge, returns on the edge that accepts
  task automatic send_item(input id_ex_t r);
    exp_q.push_back(predict(r));
    in_valid <= 1'b1;
    id_in    <= r;
    @(posedge clk);
    while (!in_ready) @(posedge clk);
    issued++;
  endtask

  task automatic finish_stream();
    in_valid <= 1'b0;
    while (exp_q.size() != 0) @(posedge clk);
    repeat (2) @(posedge clk);
  endtask

  task automatic report_test(input string name, input int err0);
    tests_run++;
    if (errors == err0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - err0);
    end
  endtask

  // output side, checks every handshake
  always @(posedge clk) begin
    if (!rst) begin
      check_bit("in_ready", in_ready, !out_valid || out_ready);
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("error at %0t ns: output transfer with no item expected", $time);
        end else begin
          exp_rec = exp_q.pop_front();
          compare_record(ex_out, exp_rec);
          checked++;
        end
      end
    end
  end

  always @(posedge clk) begin
    if (bp_on) begin
      out_ready <= bp_pattern[bp_idx[7:0]];
      bp_idx    <= bp_idx + 1;
    end
  end

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  task automatic test_reset();
    int err0;
    err0 = errors;
    check_bit("out_valid", out_valid, 1'b0);
    check_bit("in_ready", in_ready, 1'b1);
    check_ctrl("ex_out.ctrl", ex_out.ctrl, '0);
    check_word("ex_out.pc", ex_out.pc, '0);
    check_word("ex_out.alu_out", ex_out.alu_out, '0);
    check_be("ex_out.mem_byte_enable", ex_out.mem_byte_enable, 4'b0000);
    report_test("reset state", err0);
  endtask

  task automatic test_arith();
    int         err0;
    logic [6:0] op;
    err0 = errors;
    for (int f = 0; f < 8; f++) begin
      for (int s = 0; s < 2; s++) begin
        send_item(make_rec(make_instr(op_reg, f[2:0], s[0])));
        send_item(make_rec(make_instr(op_imm, f[2:0], s[0])));
      end
    end
    for (int i = 0; i < 8; i++) begin
      case (i % 4)
        0:       op = op_lui;
        1:       op = op_auipc;
        2:       op = op_jal;
        default: op = op_jalr;
      endcase
      send_item(make_rec(make_instr(op, 3'($random(seed)), 1'($random(seed)))));
    end
    finish_stream();
    report_test("arithmetic", err0);
  endtask

  task automatic test_compare();
    int             err0;
    id_ex_t         r;
    rv32i_word      bounds [5];
    branch_funct3_t br_f3 [6];
    err0   = errors;
    bounds = '{32'h0, 32'h1, 32'hffff_ffff, 32'h7fff_ffff, 32'h8000_0000};
    br_f3  = '{beq, bne, blt, bge, bltu, bgeu};
    for (int k = 0; k < 8; k++) begin
      for (int p = 0; p < 8; p++) begin
        if (k < 6) begin
          r = make_rec(make_instr(op_br, br_f3[k], 1'($random(seed))));
        end else begin
          r = make_rec(make_instr(op_reg, k[2:0] - 3'd4, 1'b0)); // slt, sltu
        end
        if (p < 5) begin
          r.rs1_data = bounds[p];
          r.rs2_data = bounds[(p + 3) % 5];
        end else if (p == 5) begin
          r.rs2_data = r.rs1_data;
        end
        send_item(r);
      end
    end
    finish_stream();
    report_test("compare", err0);
  endtask

  task automatic test_byte_enable();
    int         err0;
    id_ex_t     r;
    rv32i_word  imm;
    logic [6:0] op;
    logic [2:0] widths [8];
    err0   = errors;
    widths = '{lb, lh, lw, lbu, lhu, lb, lh, lw}; // five loads, three stores
    for (int w = 0; w < 8; w++) begin
      for (int o = 0; o < 4; o++) begin
        op  = (w < 5) ? op_load : op_store;
        r   = make_rec(make_instr(op, widths[w], 1'($random(seed))));
        imm = (w < 5) ? imm_i(r.instruction) : imm_s(r.instruction);
        r.rs1_data[1:0] = o[1:0] - imm[1:0]; // lands the address on offset o
        send_item(r);
      end
    end
    finish_stream();
    report_test("byte enables", err0);
  endtask

  task automatic test_backpressure();
    int         err0;
    id_ex_t     r;
    logic [6:0] ops [5];
    err0 = errors;
    ops  = '{op_reg, op_imm, op_load, op_store, op_br};
    for (int i = 0; i < 256; i++) begin
      bp_pattern[i] = 1'($random(seed));
    end
    bp_on <= 1'b1;
    for (int i = 0; i < n_bp; i++) begin
      r    = make_rec(make_instr(ops[{$random(seed)} % 5], 3'($random(seed)),
                                 1'($random(seed))));
      r.pc = i * 4; // sequence number for ordering
      send_item(r);
    end
    bp_on    <= 1'b0;
    in_valid <= 1'b0;
    @(posedge clk);
    out_ready <= 1'b1;
    finish_stream();
    report_test("back-pressure", err0);
  endtask

  task automatic test_unknown();
    int         err0;
    logic [6:0] ops [4];
    err0 = errors;
    ops  = '{7'b0001111, 7'b1110011, 7'b0000000, 7'b1111111};
    for (int i = 0; i < n_unknown; i++) begin
      send_item(make_rec(make_instr(ops[i], 3'($random(seed)), 1'($random(seed)))));
    end
    finish_stream();
    report_test("unknown opcode", err0);
  endtask

  initial begin
    #(watchdog_ns);
    $display("timeout: run stopped after %0d ns, %0d items still outstanding",
             watchdog_ns, exp_q.size());
    $display("Checks failed");
    $finish;
  end

  initial begin
    seed      = 34589;
    clk       = 1'b0;
    rst       = 1'b1;
    in_valid  = 1'b0;
    id_in     = '0;
    out_ready = 1'b1;
    bp_on     = 1'b0;
    bp_idx    = 0;
    errors    = 0;
    checked   = 0;
    issued    = 0;
    tests_run = 0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    test_reset();
    test_arith();
    test_compare();
    test_byte_enable();
    test_backpressure();
    test_unknown();
    $display("summary: %0d tests, %0d items issued, %0d records checked, %0d errors",
             tests_run, issued, checked, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
src/rv32i_types.sv
src/rv32i_ctrl_types.sv
src/control_rom.sv
src/operand_select.sv
src/alu.sv
src/cmp.sv
src/instruction_execute.sv
src/execute_top.sv
tests/execute_assert.sv
tests/execute_tb.sv
